/* rtl/int_divider.sv */
// serial unsigned divider
`timescale 1ns/1ns
`default_nettype none

module int_divider
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    output logic            busy,
    output logic            done,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder
);

    logic [XLEN-1:0]      rem_q;
    logic [XLEN-1:0]      quo_q;
    logic [XLEN-1:0]      div_q;
    logic [DIV_CNT_W-1:0] cnt;
    logic [XLEN-1:0]      step_rem;
    logic [XLEN-1:0]      step_quo;
    logic [XLEN-1:0]      step_div;
    logic [XLEN:0]        trial;
    logic [XLEN:0]        diff;

    // the first step works straight from the inputs, so the last one
    // lands DIV_CYCLES cycles after start
    assign step_rem = start ? '0 : rem_q;
    assign step_quo = start ? dividend : quo_q;
    assign step_div = start ? divisor : div_q;

    // shift in the next dividend bit and try the subtract
    assign trial = {step_rem, step_quo[XLEN-1]};
    assign diff  = trial - {1'b0, step_div};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= DIV_CNT_W'(DIV_CYCLES - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == DIV_CNT_W'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            div_q <= divisor;
        end
        if (start || busy) begin
            // negative difference restores the old remainder
            if (diff[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {step_quo[XLEN-2:0], 1'b0};
            end else begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {step_quo[XLEN-2:0], 1'b1};
            end
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;

    // one division at a time
    assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

/* rtl/rv_control.sv */
// core controller FSM
`timescale 1ns/1ns
`default_nettype none

module rv_control
    import rv_core_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [XLEN-1:0]      mem_rd_data,
    input  logic                 mem_ack,
    input  exec_kind_t           kind,
    input  logic [REG_SEL_W-1:0] rd_sel,
    input  logic [XLEN-1:0]      alu_result,
    input  logic [XLEN-1:0]      mem_addr_calc,
    input  logic [XLEN-1:0]      store_data,
    input  logic [XLEN-1:0]      next_pc,
    input  logic                 div_is_rem,
    input  logic                 div_done,
    input  logic [XLEN-1:0]      quotient,
    input  logic [XLEN-1:0]      remainder,
    output logic [XLEN-1:0]      instr,
    output logic [XLEN-1:0]      pc,
    output logic [XLEN-1:0]      mem_addr,
    output logic [XLEN-1:0]      mem_wr_data,
    output logic                 mem_rd_req,
    output logic                 mem_wr_req,
    output logic                 div_start,
    output logic                 wr_en,
    output logic [REG_SEL_W-1:0] wr_sel,
    output logic [XLEN-1:0]      wr_data,
    output logic [XLEN-1:0]      out_data,
    output logic                 out_valid,
    output logic                 halt
);

    ctrl_state_t state;
    logic        instr_ok;
    logic        instr_ack;
    logic        exec_go;
    logic        io_out;
    logic        io_halt;
    logic        data_go;

    // ST_EXEC has two phases, waiting for the word and executing it
    assign instr_ack = (state == ST_EXEC) && !instr_ok && mem_ack;
    assign exec_go   = (state == ST_EXEC) && instr_ok;

    assign io_out  = (mem_addr_calc == IO_OUT_ADDR);
    assign io_halt = (mem_addr_calc == IO_HALT_ADDR);
    assign data_go = exec_go && (kind == K_LOAD || (kind == K_STORE && !io_out && !io_halt));

    // writeback source
    always_comb begin
        wr_en   = 1'b0;
        wr_sel  = rd_sel;
        wr_data = alu_result;
        if (exec_go && kind == K_REG) begin
            wr_en = 1'b1;
        end else if (state == ST_MEM && mem_ack && kind == K_LOAD) begin
            wr_en   = 1'b1;
            wr_data = mem_rd_data;
        end else if (state == ST_DIV && div_done) begin
            wr_en   = 1'b1;
            wr_data = div_is_rem ? remainder : quotient;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_FETCH;
            pc         <= '0;
            instr_ok   <= 1'b0;
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            div_start  <= 1'b0;
            out_valid  <= 1'b0;
            halt       <= 1'b0;
        end else begin
            // pulses last one cycle
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            div_start  <= 1'b0;
            out_valid  <= 1'b0;
            case (state)
                ST_FETCH: begin
                    mem_rd_req <= 1'b1;
                    state      <= ST_EXEC;
                end
                ST_EXEC: begin
                    if (instr_ack) begin
                        instr_ok <= 1'b1;
                    end else if (instr_ok) begin
                        instr_ok <= 1'b0;
                        case (kind)
                            K_REG, K_BRANCH: begin
                                pc    <= next_pc;
                                state <= ST_FETCH;
                            end
                            K_LOAD: begin
                                mem_rd_req <= 1'b1;
                                state      <= ST_MEM;
                            end
                            K_STORE: begin
                                if (io_out) begin
                                    out_valid <= 1'b1;
                                    pc        <= next_pc;
                                    state     <= ST_FETCH;
                                end else if (io_halt) begin
                                    halt  <= 1'b1;
                                    state <= ST_HALT;
                                end else begin
                                    mem_wr_req <= 1'b1;
                                    state      <= ST_MEM;
                                end
                            end
                            K_DIV: begin
                                div_start <= 1'b1;
                                state     <= ST_DIV;
                            end
                            default: begin
                                halt  <= 1'b1;
                                state <= ST_HALT;
                            end
                        endcase
                    end
                end
                ST_MEM: begin
                    if (mem_ack) begin
                        pc    <= next_pc;
                        state <= ST_FETCH;
                    end
                end
                ST_DIV: begin
                    if (div_done) begin
                        pc    <= next_pc;
                        state <= ST_FETCH;
                    end
                end
                ST_HALT: state <= ST_HALT;
                default: begin
                    halt  <= 1'b1;
                    state <= ST_HALT;
                end
            endcase
        end
    end

    // instruction word, bus address and output data
    always_ff @(posedge clk) begin
        if (instr_ack) begin
            instr <= mem_rd_data;
        end
        if (state == ST_FETCH) begin
            mem_addr <= pc;
        end else if (data_go) begin
            mem_addr    <= mem_addr_calc;
            mem_wr_data <= store_data;
        end
        if (exec_go && kind == K_STORE && io_out) begin
            out_data <= store_data;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(mem_rd_req && mem_wr_req));
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
// RV32 multicycle core
`timescale 1ns/1ns
`default_nettype none

module rv_core
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] mem_rd_data,
    input  logic            mem_ack,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] mem_wr_data,
    output logic            mem_rd_req,
    output logic            mem_wr_req,
    output logic [XLEN-1:0] out_data,
    output logic            out_valid,
    output logic            halt
);

    logic [XLEN-1:0]      instr;
    logic [XLEN-1:0]      pc;
    logic [REG_SEL_W-1:0] rs1_sel;
    logic [REG_SEL_W-1:0] rs2_sel;
    logic [REG_SEL_W-1:0] rd_sel;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    exec_kind_t           kind;
    logic [XLEN-1:0]      alu_result;
    logic [XLEN-1:0]      mem_addr_calc;
    logic [XLEN-1:0]      store_data;
    logic [XLEN-1:0]      next_pc;
    logic                 div_is_rem;
    logic                 div_start;
    logic                 div_done;
    logic [XLEN-1:0]      quotient;
    logic [XLEN-1:0]      remainder;
    logic                 wr_en;
    logic [REG_SEL_W-1:0] wr_sel;
    logic [XLEN-1:0]      wr_data;

    rv_regfile i_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .wr_sel   (wr_sel),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_exec_unit i_exec (
        .instr         (instr),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .rs1_sel       (rs1_sel),
        .rs2_sel       (rs2_sel),
        .rd_sel        (rd_sel),
        .kind          (kind),
        .alu_result    (alu_result),
        .mem_addr_calc (mem_addr_calc),
        .store_data    (store_data),
        .next_pc       (next_pc),
        .div_is_rem    (div_is_rem)
    );

    // divider sees the same operands as the ALU; busy is only checked inside it
    int_divider i_divider (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .dividend  (rs1_data),
        .divisor   (rs2_data),
        .busy      (),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    rv_control i_control (
        .clk           (clk),
        .rst           (rst),
        .mem_rd_data   (mem_rd_data),
        .mem_ack       (mem_ack),
        .kind          (kind),
        .rd_sel        (rd_sel),
        .alu_result    (alu_result),
        .mem_addr_calc (mem_addr_calc),
        .store_data    (store_data),
        .next_pc       (next_pc),
        .div_is_rem    (div_is_rem),
        .div_done      (div_done),
        .quotient      (quotient),
        .remainder     (remainder),
        .instr         (instr),
        .pc            (pc),
        .mem_addr      (mem_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_rd_req    (mem_rd_req),
        .mem_wr_req    (mem_wr_req),
        .div_start     (div_start),
        .wr_en         (wr_en),
        .wr_sel        (wr_sel),
        .wr_data       (wr_data),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .halt          (halt)
    );

endmodule

`default_nettype wire

/* rtl/rv_core_pkg.sv */
// RV32 core shared definitions
`default_nettype none

package rv_core_pkg;

    // widths
    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_SEL_W  = 5;
    localparam int DIV_CYCLES = 32;
    localparam int DIV_CNT_W  = $clog2(DIV_CYCLES);

    // major opcodes
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // op-imm funct3
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_XORI  = 3'b100;
    localparam logic [2:0] F3_ORI   = 3'b110;
    localparam logic [2:0] F3_ANDI  = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // word width for loads and stores
    localparam logic [2:0] F3_WORD = 3'b010;

    // register ops, funct7 followed by funct3
    localparam logic [9:0] FN_ADD  = {7'b0000000, 3'b000};
    localparam logic [9:0] FN_SUB  = {7'b0100000, 3'b000};
    localparam logic [9:0] FN_SLL  = {7'b0000000, 3'b001};
    localparam logic [9:0] FN_SRL  = {7'b0000000, 3'b101};
    localparam logic [9:0] FN_SLTU = {7'b0000000, 3'b011};
    localparam logic [9:0] FN_AND  = {7'b0000000, 3'b111};
    localparam logic [9:0] FN_OR   = {7'b0000000, 3'b110};
    localparam logic [9:0] FN_XOR  = {7'b0000000, 3'b100};
    localparam logic [9:0] FN_MUL  = {7'b0000001, 3'b000};
    localparam logic [9:0] FN_DIVU = {7'b0000001, 3'b101};
    localparam logic [9:0] FN_REMU = {7'b0000001, 3'b111};

    // memory-mapped I/O
    localparam logic [XLEN-1:0] IO_OUT_ADDR  = 32'd1000;
    localparam logic [XLEN-1:0] IO_HALT_ADDR = 32'd1004;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM,
        ST_DIV,
        ST_HALT
    } ctrl_state_t;

    typedef enum logic [2:0] {
        K_REG,
        K_BRANCH,
        K_LOAD,
        K_STORE,
        K_DIV,
        K_ILLEGAL
    } exec_kind_t;

endpackage

`default_nettype wire

/* rtl/rv_exec_unit.sv */
// instruction decode and ALU
`timescale 1ns/1ns
`default_nettype none

module rv_exec_unit
    import rv_core_pkg::*;
(
    input  logic [XLEN-1:0]      instr,
    input  logic [XLEN-1:0]      pc,
    input  logic [XLEN-1:0]      rs1_data,
    input  logic [XLEN-1:0]      rs2_data,
    output logic [REG_SEL_W-1:0] rs1_sel,
    output logic [REG_SEL_W-1:0] rs2_sel,
    output logic [REG_SEL_W-1:0] rd_sel,
    output exec_kind_t           kind,
    output logic [XLEN-1:0]      alu_result,
    output logic [XLEN-1:0]      mem_addr_calc,
    output logic [XLEN-1:0]      store_data,
    output logic [XLEN-1:0]      next_pc,
    output logic                 div_is_rem
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [9:0]      fn;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic            branch_taken;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign fn      = {instr[31:25], instr[14:12]};
    assign rd_sel  = instr[11:7];
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];

    // sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    assign mem_addr_calc = rs1_data + ((opcode == OPC_STORE) ? imm_s : imm_i);
    assign store_data    = rs2_data;
    assign next_pc       = pc + (branch_taken ? imm_b : XLEN'(4));

    always_comb begin
        kind         = K_ILLEGAL;
        alu_result   = '0;
        branch_taken = 1'b0;
        div_is_rem   = 1'b0;
        case (opcode)
            OPC_OPIMM: begin
                kind = K_REG;
                case (funct3)
                    F3_ADDI:  alu_result = rs1_data + imm_i;
                    F3_SLTIU: alu_result = XLEN'(rs1_data < imm_i);
                    F3_XORI:  alu_result = rs1_data ^ imm_i;
                    F3_ORI:   alu_result = rs1_data | imm_i;
                    F3_ANDI:  alu_result = rs1_data & imm_i;
                    default:  kind = K_ILLEGAL;
                endcase
            end
            OPC_OP: begin
                kind = K_REG;
                case (fn)
                    FN_ADD:  alu_result = rs1_data + rs2_data;
                    FN_SUB:  alu_result = rs1_data - rs2_data;
                    FN_SLL:  alu_result = rs1_data << rs2_data[4:0];
                    FN_SRL:  alu_result = rs1_data >> rs2_data[4:0];
                    FN_SLTU: alu_result = XLEN'(rs1_data < rs2_data);
                    FN_AND:  alu_result = rs1_data & rs2_data;
                    FN_OR:   alu_result = rs1_data | rs2_data;
                    FN_XOR:  alu_result = rs1_data ^ rs2_data;
                    // low word of the product
                    FN_MUL:  alu_result = rs1_data * rs2_data;
                    FN_DIVU: kind = K_DIV;
                    FN_REMU: begin
                        kind       = K_DIV;
                        div_is_rem = 1'b1;
                    end
                    default: kind = K_ILLEGAL;
                endcase
            end
            OPC_LOAD: begin
                if (funct3 == F3_WORD) begin
                    kind = K_LOAD;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_WORD) begin
                    kind = K_STORE;
                end
            end
            OPC_BRANCH: begin
                kind = K_BRANCH;
                case (funct3)
                    F3_BEQ:  branch_taken = (rs1_data == rs2_data);
                    F3_BNE:  branch_taken = (rs1_data != rs2_data);
                    F3_BLTU: branch_taken = (rs1_data < rs2_data);
                    F3_BGEU: branch_taken = (rs1_data >= rs2_data);
                    default: kind = K_ILLEGAL;
                endcase
            end
            OPC_LUI: begin
                kind       = K_REG;
                alu_result = imm_u;
            end
            default: kind = K_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
// integer register file
`timescale 1ns/1ns
`default_nettype none

module rv_regfile
    import rv_core_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [REG_SEL_W-1:0] rs1_sel,
    input  logic [REG_SEL_W-1:0] rs2_sel,
    input  logic [REG_SEL_W-1:0] wr_sel,
    input  logic                 wr_en,
    input  logic [XLEN-1:0]      wr_data,
    output logic [XLEN-1:0]      rs1_data,
    output logic [XLEN-1:0]      rs2_data
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // x0 is never written, so it reads back as zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_sel];
    assign rs2_data = regs[rs2_sel];

endmodule

`default_nettype wire

/* tb.f */
rtl/rv_core_pkg.sv
rtl/rv_regfile.sv
rtl/rv_exec_unit.sv
rtl/int_divider.sv
rtl/rv_control.sv
rtl/rv_core.sv
verification/rv_core_checker.sv
verification/tb_rv_core.sv

/* verification/rv_core_checker.sv */
// core output checker
`timescale 1ns/1ns
`default_nettype none

module rv_core_checker
    import rv_core_pkg::*;
#(
    parameter int N_WORDS = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             out_valid,
    input  logic [XLEN-1:0]                  out_data,
    input  logic                             halt,
    input  logic [0:N_WORDS-1][XLEN-1:0]     exp_words,
    input  int                               exp_count,
    output int                               word_count,
    output int                               error_count
);

    logic halt_seen;

    initial begin
        error_count = 0;
        word_count  = 0;
        halt_seen   = 1'b0;
    end

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (rst) begin
            word_count = 0;
            halt_seen  = 1'b0;
        end else begin
            if ($isunknown({out_valid, halt})) begin
                $display("[%0t] out_valid or halt is unknown after reset", $time);
                error_count++;
            end
            if (out_valid) begin
                if (word_count >= exp_count) begin
                    $display("[%0t] extra output word 0x%08h, only %0d expected",
                             $time, out_data, exp_count);
                    error_count++;
                end else if (out_data !== exp_words[word_count]) begin
                    $display("CHECK FAILED at %0t ns: out_data word %0d expected 0x%08h, got 0x%08h",
                             $time, word_count, exp_words[word_count], out_data);
                    error_count++;
                end
                word_count++;
            end
            // judge the word count once, when the core stops
            if (halt && !halt_seen) begin
                halt_seen = 1'b1;
                if (word_count < exp_count) begin
                    $display("[%0t] core halted after %0d output words, %0d expected",
                             $time, word_count, exp_count);
                    error_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_rv_core.sv */
// RV32 core testbench
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core
    import rv_core_pkg::*;
();

    localparam int NUM_TESTS    = 7;
    localparam int MAX_WORDS    = 12;
    localparam int MAX_OUT      = 4;
    localparam int MEM_WORDS    = 256;
    localparam int HALT_TIMEOUT = 2000;

    logic            clk;
    logic            rst;
    logic [XLEN-1:0] mem_rd_data;
    logic            mem_ack;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wr_data;
    logic            mem_rd_req;
    logic            mem_wr_req;
    logic [XLEN-1:0] out_data;
    logic            out_valid;
    logic            halt;

    logic [0:MAX_OUT-1][XLEN-1:0] exp_words;
    int                           exp_count;
    int                           word_count;
    int                           error_count;

    // program table, one row per test
    logic [0:MAX_WORDS-1][XLEN-1:0] prog_tab [NUM_TESTS];
    logic [0:MAX_OUT-1][XLEN-1:0]   exp_tab  [NUM_TESTS];
    int                             exp_cnt  [NUM_TESTS];
    string                          name_tab [NUM_TESTS];

    // memory model state
    logic [XLEN-1:0] mem [MEM_WORDS];
    logic [31:0]     lfsr;
    logic [1:0]      delay_bits;
    logic [XLEN-1:0] rd_word;
    int              ack_wait;

    int pass_count;
    int fail_count;

    rv_core i_dut (
        .clk         (clk),
        .rst         (rst),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halt        (halt)
    );

    rv_core_checker #(
        .N_WORDS (MAX_OUT)
    ) i_checker (
        .clk         (clk),
        .rst         (rst),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .halt        (halt),
        .exp_words   (exp_words),
        .exp_count   (exp_count),
        .word_count  (word_count),
        .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, right-shifting form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // unused words decode as an illegal opcode
    function automatic logic [XLEN-1:0] fill_word(input int idx);
        return 32'hee00_007f | (XLEN'(idx) << 8);
    endfunction

    // one request at a time, acknowledged 1 to 4 cycles later
    always @(negedge clk) begin
        mem_ack = 1'b0;
        if (rst) begin
            ack_wait = 0;
        end else if (ack_wait > 0) begin
            ack_wait = ack_wait - 1;
            if (ack_wait == 0) begin
                mem_ack     = 1'b1;
                mem_rd_data = rd_word;
            end
        end else if (mem_rd_req || mem_wr_req) begin
            if (mem_wr_req) begin
                mem[mem_addr[9:2]] = mem_wr_data;
            end
            rd_word       = mem[mem_addr[9:2]];
            delay_bits[0] = lfsr[0];
            lfsr          = lfsr_next(lfsr);
            delay_bits[1] = lfsr[0];
            lfsr          = lfsr_next(lfsr);
            ack_wait      = 1 + int'(delay_bits);
        end
    end

    task automatic fill_tables();
        // addi, xori, andi, ori, sltiu, lui
        prog_tab[0] = {32'hFFD00093, 32'h0F00C113, 32'h3E202423, 32'h6F017193,
                       32'h02A1E193, 32'h3E302423, 32'hFFF0B213, 32'h3E402423,
                       32'hABCDE2B7, 32'hFFF28293, 32'h3E502423, 32'h3E002623};
        exp_tab[0]  = {32'hFFFFFF0D, 32'h0000062A, 32'h00000001, 32'hABCDDFFF};
        exp_cnt[0]  = 4;
        name_tab[0] = "immediates";
        // sub and add wrap, sll by rs2[4:0], srl, sltu
        prog_tab[1] = {32'h00300093, 32'hFFA00113, 32'h402081B3, 32'h3E302423,
                       32'h00310233, 32'h3E402423, 32'h002112B3, 32'h0012D333,
                       32'h3E602423, 32'h0020B3B3, 32'h3E702423, 32'h3E002623};
        exp_tab[1]  = {32'h00000009, 32'h00000003, 32'h1D000000, 32'h00000001};
        exp_cnt[1]  = 4;
        name_tab[1] = "register arith";
        prog_tab[2] = {32'h5A500093, 32'h12345137, 32'h67810113, 32'h0020F1B3,
                       32'h3E302423, 32'h0020E233, 32'h3E402423, 32'h0020C2B3,
                       32'h3E502423, 32'h02210333, 32'h3E602423, 32'h3E002623};
        exp_tab[2]  = {32'h00000420, 32'h123457FD, 32'h123453DD, 32'h1DF4D840};
        exp_cnt[2]  = 4;
        name_tab[2] = "register logic mul";
        // two stores at 0x204 and 0x208, then load both back
        prog_tab[3] = {32'hCAFEB0B7, 32'h0BE08093, 32'h20000113, 32'h00112223,
                       32'h00212423, 32'h00412183, 32'h00812203, 32'h3E302423,
                       32'h3E402423, 32'h004182B3, 32'h3E502423, 32'h3E002623};
        exp_tab[3]  = {32'hCAFEB0BE, 32'h00000200, 32'hCAFEB2BE, 32'h00000000};
        exp_cnt[3]  = 3;
        name_tab[3] = "load store";
        // bne loop sums 5 down to 1, then beq and bltu skip, bgeu falls through
        prog_tab[4] = {32'h00500093, 32'h00110133, 32'hFFF08093, 32'hFE009CE3,
                       32'h3E202423, 32'h00008463, 32'h3E102423, 32'h0020E463,
                       32'h3E002423, 32'h0020F463, 32'h3E102423, 32'h3E002623};
        exp_tab[4]  = {32'h0000000F, 32'h00000000, 32'h00000000, 32'h00000000};
        exp_cnt[4]  = 2;
        name_tab[4] = "branches";
        prog_tab[5] = {32'h06400093, 32'h00700113, 32'h0220D1B3, 32'h3E302423,
                       32'h0220F233, 32'h3E402423, 32'h0200D2B3, 32'h3E502423,
                       32'h0200F333, 32'h3E602423, 32'h3E002623, 32'h00000000};
        exp_tab[5]  = {32'h0000000E, 32'h00000002, 32'hFFFFFFFF, 32'h00000064};
        exp_cnt[5]  = 4;
        name_tab[5] = "divide";
        // addi to x0, store x0, then an illegal word ahead of one more store
        prog_tab[6] = {32'h03700013, 32'h3E002423, 32'h00100093, 32'hFFFFFFFF,
                       32'h3E102423, 32'h3E002623, 32'h00000000, 32'h00000000,
                       32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000};
        exp_tab[6]  = {32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000};
        exp_cnt[6]  = 1;
        name_tab[6] = "illegal and x0";
    endtask

    task automatic load_program(input int t);
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        for (i = 0; i < MAX_WORDS; i++) begin
            mem[i] = prog_tab[t][i];
        end
    endtask

    task automatic run_test(input int t);
        int   errs_before;
        int   cycles;
        logic ok;
        errs_before = error_count;
        rst         = 1'b1;
        exp_words   = exp_tab[t];
        exp_count   = exp_cnt[t];
        load_program(t);
        repeat (4) @(negedge clk);
        rst    = 1'b0;
        cycles = 0;
        while (!halt && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        // give the checker its edge to judge the halt
        @(negedge clk);
        ok = (error_count == errs_before);
        if (!halt) begin
            $display("test %s: core did not halt within %0d cycles", name_tab[t], HALT_TIMEOUT);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %-20s %s, %0d of %0d words, %0d cycles", name_tab[t],
                 ok ? "ok" : "FAILED", word_count, exp_cnt[t], cycles);
    endtask

    initial begin
        rst         = 1'b1;
        mem_ack     = 1'b0;
        mem_rd_data = '0;
        exp_words   = '0;
        exp_count   = 0;
        lfsr        = 32'hb2ff;
        ack_wait    = 0;
        pass_count  = 0;
        fail_count  = 0;
        fill_tables();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests %0d, passed %0d, failed %0d, check errors %0d",
                 NUM_TESTS, pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
